// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_disparity_map
FILELIST = sources.f

BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and logs"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: no errors" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rtl/disparity_map.sv ====
//********************
// disparity pipeline top: stage chain, SAD adders,
// alignment delay lines and minimum search
//********************

module disparity_map (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  disparity_pkg::window_t i_win_l,
    input  disparity_pkg::window_t i_win_r,

    output logic                   o_valid,
    output disparity_pkg::disp_t   o_disparity,
    output disparity_pkg::sad_t    o_min_sad
);

    // entry 0 is the port, entry d+1 is the output of stage d
    logic                   valid_chain [disparity_pkg::DISP_NUM+1];
    disparity_pkg::window_t win_l_chain [disparity_pkg::DISP_NUM];
    disparity_pkg::window_t diff        [disparity_pkg::DISP_NUM];

    logic                   sad_valid   [disparity_pkg::DISP_NUM];
    disparity_pkg::sad_t    sad         [disparity_pkg::DISP_NUM];

    logic                   al_valid;
    disparity_pkg::sad_t    al_sad      [disparity_pkg::DISP_NUM];

    assign valid_chain[0] = i_valid;
    assign win_l_chain[0] = i_win_l;

    generate
        for (genvar gen = 0; gen < disparity_pkg::DISP_NUM; gen++) begin : g_stage
            if (gen < disparity_pkg::DISP_NUM - 1) begin : g_mid
                window_abs_stage window_abs_stage_i (
                    .i_clk   (i_clk),
                    .i_rst_n (i_rst_n),
                    .i_valid (valid_chain[gen]),
                    .i_win_l (win_l_chain[gen]),
                    .i_win_r (i_win_r),
                    .o_valid (valid_chain[gen+1]),
                    .o_win_l (win_l_chain[gen+1]),
                    .o_diff  (diff[gen])
                );
            end else begin : g_last
                // left window has no further stage to visit
                window_abs_stage window_abs_stage_i (
                    .i_clk   (i_clk),
                    .i_rst_n (i_rst_n),
                    .i_valid (valid_chain[gen]),
                    .i_win_l (win_l_chain[gen]),
                    .i_win_r (i_win_r),
                    .o_valid (valid_chain[gen+1]),
                    .o_win_l (),
                    .o_diff  (diff[gen])
                );
            end

            window_sad window_sad_i (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_valid (valid_chain[gen+1]),
                .i_diff  (diff[gen]),
                .o_valid (sad_valid[gen]),
                .o_sad   (sad[gen])
            );

            // stage d is d cycles late, pad the early ones
            if (gen == 0) begin : g_ref
                sad_delay_line #(
                    .DEPTH (disparity_pkg::DISP_NUM - 1 - gen)
                ) sad_delay_line_i (
                    .i_clk   (i_clk),
                    .i_rst_n (i_rst_n),
                    .i_valid (sad_valid[gen]),
                    .i_sad   (sad[gen]),
                    .o_valid (al_valid),
                    .o_sad   (al_sad[gen])
                );
            end else begin : g_other
                sad_delay_line #(
                    .DEPTH (disparity_pkg::DISP_NUM - 1 - gen)
                ) sad_delay_line_i (
                    .i_clk   (i_clk),
                    .i_rst_n (i_rst_n),
                    .i_valid (sad_valid[gen]),
                    .i_sad   (sad[gen]),
                    .o_valid (),
                    .o_sad   (al_sad[gen])
                );
            end
        end
    endgenerate

    // all SADs of one beat meet here DISP_NUM+1 edges after the beat
    min_disparity min_disparity_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (al_valid),
        .i_sad       (al_sad),
        .o_valid     (o_valid),
        .o_disparity (o_disparity),
        .o_min_sad   (o_min_sad)
    );

endmodule

// ==== rtl/disparity_pkg.sv ====
//********************
// sizing constants and data types shared by the
// block-matching disparity pipeline
//********************

package disparity_pkg;

    // window geometry
    localparam int WIN_N   = 3;
    localparam int WIN_PIX = WIN_N * WIN_N;

    // pixel depth
    localparam int PIX_W = 8;

    // disparity search range, DISP_NUM must equal 2**DISP_W for the min tree
    localparam int DISP_NUM = 8;
    localparam int DISP_W   = 3;

    // 9 x 255 = 2295 fits in 12 bits
    localparam int SAD_W = 12;

    // one grey-level pixel
    typedef logic [PIX_W-1:0] pixel_t;

    // row-major window, index 0 is top left, index 8 bottom right
    typedef pixel_t [WIN_PIX-1:0] window_t;

    // matching cost of one disparity
    typedef logic [SAD_W-1:0] sad_t;

    // disparity index
    typedef logic [DISP_W-1:0] disp_t;

endpackage

// ==== rtl/min_disparity.sv ====
//********************
// comparator tree picking the lowest SAD,
// registered with its index and valid
//********************

module min_disparity (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,
    input  disparity_pkg::sad_t  i_sad [disparity_pkg::DISP_NUM],

    output logic                 o_valid,
    output disparity_pkg::disp_t o_disparity,
    output disparity_pkg::sad_t  o_min_sad
);

    // level 0 holds the inputs, level DISP_W holds the winner in slot 0
    disparity_pkg::sad_t  lvl_sad [disparity_pkg::DISP_W+1][disparity_pkg::DISP_NUM];
    disparity_pkg::disp_t lvl_idx [disparity_pkg::DISP_W+1][disparity_pkg::DISP_NUM];

    always_comb begin
        for (int l = 0; l <= disparity_pkg::DISP_W; l++) begin
            for (int j = 0; j < disparity_pkg::DISP_NUM; j++) begin
                lvl_sad[l][j] = '0;
                lvl_idx[l][j] = '0;
            end
        end

        for (int j = 0; j < disparity_pkg::DISP_NUM; j++) begin
            lvl_sad[0][j] = i_sad[j];
            lvl_idx[0][j] = disparity_pkg::disp_t'(j);
        end

        // left operand always covers the lower indices,
        // so strict compare keeps the lower index on a tie
        for (int l = 0; l < disparity_pkg::DISP_W; l++) begin
            for (int j = 0; j < (disparity_pkg::DISP_NUM >> (l + 1)); j++) begin
                if (lvl_sad[l][2*j+1] < lvl_sad[l][2*j]) begin
                    lvl_sad[l+1][j] = lvl_sad[l][2*j+1];
                    lvl_idx[l+1][j] = lvl_idx[l][2*j+1];
                end else begin
                    lvl_sad[l+1][j] = lvl_sad[l][2*j];
                    lvl_idx[l+1][j] = lvl_idx[l][2*j];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_disparity <= '0;
            o_min_sad   <= '0;
        end else begin
            o_valid     <= i_valid;
            o_disparity <= lvl_idx[disparity_pkg::DISP_W][0];
            o_min_sad   <= lvl_sad[disparity_pkg::DISP_W][0];
        end
    end

endmodule

// ==== rtl/sad_delay_line.sv ====
//********************
// shift register that delays a SAD and its valid
//********************

module sad_delay_line #(
    parameter int DEPTH = 1
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  disparity_pkg::sad_t i_sad,

    output logic                o_valid,
    output disparity_pkg::sad_t o_sad
);

    generate
        if (DEPTH == 0) begin : g_pass
            // last disparity is already aligned
            assign o_valid = i_valid;
            assign o_sad   = i_sad;
        end else begin : g_shift
            logic                valid_sr [DEPTH];
            disparity_pkg::sad_t sad_sr   [DEPTH];

            always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        valid_sr[i] <= 1'b0;
                        sad_sr[i]   <= '0;
                    end
                end else begin
                    valid_sr[0] <= i_valid;
                    sad_sr[0]   <= i_sad;
                    for (int i = 1; i < DEPTH; i++) begin
                        valid_sr[i] <= valid_sr[i-1];
                        sad_sr[i]   <= sad_sr[i-1];
                    end
                end
            end

            assign o_valid = valid_sr[DEPTH-1];
            assign o_sad   = sad_sr[DEPTH-1];
        end
    endgenerate

endmodule

// ==== rtl/window_abs_stage.sv ====
//********************
// one matching stage: forwards the left window
// and registers per-pixel absolute differences
//********************

module window_abs_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  disparity_pkg::window_t i_win_l,
    input  disparity_pkg::window_t i_win_r,

    output logic                   o_valid,
    output disparity_pkg::window_t o_win_l,
    output disparity_pkg::window_t o_diff
);

    disparity_pkg::window_t diff_c;

    // |l - r| per pixel, no sign bit needed
    always_comb begin
        for (int i = 0; i < disparity_pkg::WIN_PIX; i++) begin
            if (i_win_l[i] > i_win_r[i]) begin
                diff_c[i] = i_win_l[i] - i_win_r[i];
            end else begin
                diff_c[i] = i_win_r[i] - i_win_l[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_win_l <= '0;
            o_diff  <= '0;
        end else begin
            o_valid <= i_valid;
            // left window moves one stage on, so it meets the next right window
            o_win_l <= i_win_l;
            o_diff  <= diff_c;
        end
    end

endmodule

// ==== rtl/window_sad.sv ====
//********************
// two-cycle adder tree, nine absolute
// differences into one SAD
//********************

module window_sad (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  disparity_pkg::window_t i_diff,

    output logic                   o_valid,
    output disparity_pkg::sad_t    o_sad
);

    disparity_pkg::sad_t row_sum [disparity_pkg::WIN_N];
    disparity_pkg::sad_t row_q   [disparity_pkg::WIN_N];
    logic                valid_q;
    disparity_pkg::sad_t total;

    // first level, one sum per window row
    always_comb begin
        for (int r = 0; r < disparity_pkg::WIN_N; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < disparity_pkg::WIN_N; c++) begin
                row_sum[r] = row_sum[r]
                           + disparity_pkg::sad_t'(i_diff[r * disparity_pkg::WIN_N + c]);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            for (int r = 0; r < disparity_pkg::WIN_N; r++) begin
                row_q[r] <= '0;
            end
        end else begin
            valid_q <= i_valid;
            for (int r = 0; r < disparity_pkg::WIN_N; r++) begin
                row_q[r] <= row_sum[r];
            end
        end
    end

    // second level, total of the registered rows
    always_comb begin
        total = '0;
        for (int r = 0; r < disparity_pkg::WIN_N; r++) begin
            total = total + row_q[r];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_sad   <= '0;
        end else begin
            o_valid <= valid_q;
            o_sad   <= total;
        end
    end

endmodule

// ==== sources.f ====
rtl/disparity_pkg.sv
rtl/window_abs_stage.sv
rtl/window_sad.sv
rtl/sad_delay_line.sv
rtl/min_disparity.sv
rtl/disparity_map.sv
verif/disparity_map_sva.sv
verif/tb_disparity_map.sv

// ==== verif/disparity_map_sva.sv ====
//********************
// concurrent assertions on the disparity top,
// bound into disparity_map
//********************

module disparity_map_sva (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic                 i_valid,
    input logic                 i_out_valid,
    input disparity_pkg::disp_t i_disparity,
    input disparity_pkg::sad_t  i_min_sad
);
    timeunit 1ns;
    timeprecision 1ps;

    a_quiet_in_reset : assert property (@(posedge i_clk)
        !i_rst_n |=> !i_out_valid)
        else $error("o_valid high during reset");

    // output flop updates DISP_NUM+2 edges after the beat, seen one sample later
    a_fixed_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid == $past(i_valid, disparity_pkg::DISP_NUM + 3))
        else $error("o_valid does not follow i_valid at the pipeline latency");

    a_known_result : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> !$isunknown({i_disparity, i_min_sad}))
        else $error("unknown result while o_valid is high");

    a_sad_range : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid |-> i_min_sad <= disparity_pkg::sad_t'(
            disparity_pkg::WIN_PIX * ((1 << disparity_pkg::PIX_W) - 1)))
        else $error("o_min_sad above the largest possible SAD");

endmodule

bind disparity_map disparity_map_sva disparity_map_sva_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_disparity (o_disparity),
    .i_min_sad   (o_min_sad)
);

// ==== verif/tb_disparity_map.sv ====
//********************
// directed testbench for the disparity pipeline:
// clock, reset, reference model, compare tasks
//********************

module tb_disparity_map;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int LATENCY        = 10;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED           = 32'h22f0_eafb;

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    logic                   i_valid;
    disparity_pkg::window_t i_win_l;
    disparity_pkg::window_t i_win_r;
    logic                   o_valid;
    disparity_pkg::disp_t   o_disparity;
    disparity_pkg::sad_t    o_min_sad;

    // every sampled right window, indexed by clock edge
    disparity_pkg::window_t r_hist [TIMEOUT_CYCLES];
    disparity_pkg::window_t left_q [$];
    int                     beat_cyc_q [$];
    int                     cycle_count  = 0;
    int                     results_seen = 0;
    // directed tests with a known answer set these, -1 means none
    int                     fixed_disp   = -1;
    disparity_pkg::sad_t    fixed_sad    = '0;

    disparity_pkg::window_t mon_win;
    int                     mon_cyc;
    disparity_pkg::disp_t   exp_disp;
    disparity_pkg::sad_t    exp_sad;

    disparity_map disparity_map_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_win_l     (i_win_l),
        .i_win_r     (i_win_r),
        .o_valid     (o_valid),
        .o_disparity (o_disparity),
        .o_min_sad   (o_min_sad)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_disp(input string name, input disparity_pkg::disp_t got,
                              input disparity_pkg::disp_t want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    task automatic check_sad(input string name, input disparity_pkg::sad_t got,
                             input disparity_pkg::sad_t want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    function automatic disparity_pkg::sad_t window_cost(input disparity_pkg::window_t l,
                                                        input disparity_pkg::window_t r);
        int acc;
        acc = 0;
        for (int p = 0; p < disparity_pkg::WIN_PIX; p++) begin
            if (l[p] >= r[p]) begin
                acc = acc + int'(l[p]) - int'(r[p]);
            end else begin
                acc = acc + int'(r[p]) - int'(l[p]);
            end
        end
        return disparity_pkg::sad_t'(acc);
    endfunction

    // lowest cost over all offsets, first index wins a tie
    task automatic expect_result(input disparity_pkg::window_t l, input int c,
                                 output disparity_pkg::disp_t d_best,
                                 output disparity_pkg::sad_t s_best);
        disparity_pkg::sad_t cost;
        d_best = '0;
        s_best = '0;
        for (int d = 0; d < disparity_pkg::DISP_NUM; d++) begin
            cost = window_cost(l, r_hist[c + d]);
            if (d == 0 || cost < s_best) begin
                d_best = disparity_pkg::disp_t'(d);
                s_best = cost;
            end
        end
    endtask

    function automatic disparity_pkg::window_t flat_window(input int v);
        disparity_pkg::window_t w;
        for (int p = 0; p < disparity_pkg::WIN_PIX; p++) begin
            w[p] = disparity_pkg::pixel_t'(v);
        end
        return w;
    endfunction

    // windows up to 15 steps apart never match
    function automatic disparity_pkg::window_t shift_window(input int n);
        disparity_pkg::window_t w;
        for (int p = 0; p < disparity_pkg::WIN_PIX; p++) begin
            w[p] = disparity_pkg::pixel_t'(n * 16 + p * 3 + 5);
        end
        return w;
    endfunction

    function automatic disparity_pkg::window_t rand_window(input int max_pix);
        disparity_pkg::window_t w;
        for (int p = 0; p < disparity_pkg::WIN_PIX; p++) begin
            w[p] = disparity_pkg::pixel_t'($urandom_range(max_pix, 0));
        end
        return w;
    endfunction

    task automatic drive(input logic v, input disparity_pkg::window_t l,
                         input disparity_pkg::window_t r);
        @(negedge i_clk);
        i_valid = v;
        i_win_l = l;
        i_win_r = r;
    endtask

    // results trail the last beat by the fixed pipeline latency
    task automatic wait_drain();
        @(negedge i_clk);
        i_valid = 1'b0;
        repeat (LATENCY + 1) begin
            @(posedge i_clk);
        end
    endtask

    // input sampling, model history and timeout
    always @(posedge i_clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
        end else begin
            r_hist[cycle_count] = i_win_r;
            if (i_valid) begin
                left_q.push_back(i_win_l);
                beat_cyc_q.push_back(cycle_count);
            end
            cycle_count = cycle_count + 1;
        end
    end

    // results are stable here, half a cycle after the output flops
    always @(negedge i_clk) begin
        if (o_valid) begin
            if (left_q.size() == 0) begin
                abort_run("o_valid went high with no input beat outstanding");
            end else begin
                mon_win = left_q.pop_front();
                mon_cyc = beat_cyc_q.pop_front();
                results_seen = results_seen + 1;
                if (cycle_count - 1 - mon_cyc != LATENCY) begin
                    abort_run($sformatf("result came %0d cycles after its beat, not %0d",
                                        cycle_count - 1 - mon_cyc, LATENCY));
                end
                expect_result(mon_win, mon_cyc, exp_disp, exp_sad);
                check_disp("o_disparity", o_disparity, exp_disp);
                check_sad("o_min_sad", o_min_sad, exp_sad);
                if (fixed_disp >= 0) begin
                    check_disp("o_disparity", o_disparity, disparity_pkg::disp_t'(fixed_disp));
                    check_sad("o_min_sad", o_min_sad, fixed_sad);
                end
            end
        end
    end

    task automatic reset_quiet();
        i_rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            if (o_valid !== 1'b0) begin
                abort_run("o_valid went high while reset was held");
            end
        end
        i_rst_n = 1'b1;
        drive(1'b1, rand_window(255), rand_window(255));
        wait_drain();
    endtask

    task automatic uniform_image();
        fixed_disp = 0;
        fixed_sad  = '0;
        repeat (20) begin
            drive(1'b1, flat_window(8'h5a), flat_window(8'h5a));
        end
        wait_drain();
        fixed_disp = -1;
    endtask

    // right stream repeats the left stream d cycles later
    task automatic known_shift(input int d);
        fixed_disp = d;
        fixed_sad  = '0;
        for (int n = 0; n < 16 + disparity_pkg::DISP_NUM - 1; n++) begin
            drive(n < 16, shift_window(n), shift_window(n - d));
        end
        wait_drain();
        fixed_disp = -1;
    endtask

    // both offsets cost 9, the rest cost 360
    task automatic tie_break(input int lo, input int hi);
        fixed_disp = lo;
        fixed_sad  = disparity_pkg::sad_t'(disparity_pkg::WIN_PIX);
        for (int e = 0; e < disparity_pkg::DISP_NUM; e++) begin
            drive(e == 0, flat_window(100),
                  flat_window(e == lo ? 101 : (e == hi ? 99 : 140)));
        end
        wait_drain();
        fixed_disp = -1;
    endtask

    task automatic random_stream(input int beats);
        repeat (beats) begin
            drive(1'b1, rand_window(255), rand_window(255));
        end
        wait_drain();
    endtask

    // small pixel range, so ties show up often
    task automatic gapped_valid();
        int   sent;
        int   seen_before;
        logic v;
        sent        = 0;
        seen_before = results_seen;
        for (int n = 0; n < 120; n++) begin
            v = ($urandom_range(2, 0) != 0);
            if (v) begin
                sent++;
            end
            drive(v, rand_window(15), rand_window(15));
        end
        wait_drain();
        if (results_seen - seen_before != sent) begin
            abort_run($sformatf("%0d valid beats gave %0d results",
                                sent, results_seen - seen_before));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_win_l = '0;
        i_win_r = '0;

        reset_quiet();
        uniform_image();
        known_shift(0);
        known_shift(3);
        known_shift(5);
        known_shift(7);
        tie_break(2, 5);
        tie_break(0, 7);
        tie_break(3, 4);
        tie_break(6, 7);
        random_stream(200);
        gapped_valid();

        if (left_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never appeared", left_q.size()));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
